/* tb.f */
+incdir+logic
logic/vred_pkg.sv
logic/vred_operand_mask.sv
logic/vred_tree_stage.sv
logic/vred_datapath.sv
logic/vred_ctrl.sv
logic/vred_top.sv
verification/vred_clk_gen.sv
verification/vred_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vred_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TB PASSED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/vred_tb.sv */
`include "vred_settings.svh"

module vred_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_WAIT = 20;
    localparam int SRC_W = `VRED_SRC_W;

    logic                      clk;
    logic                      nrst;
    logic                      req;
    vred_pkg::vred_cmd_t       cmd;
    logic                      ack;
    logic [`VRED_SCALAR_W-1:0] result;

    int tests;
    int failed_tests;
    int errors;

    vred_clk_gen i_clk_gen (
        .clk  (clk),
        .nrst (nrst)
    );

    vred_top i_dut (
        .clk    (clk),
        .nrst   (nrst),
        .req    (req),
        .cmd    (cmd),
        .ack    (ack),
        .result (result)
    );

    task automatic check_value(input string sig, input longint got, input longint exp);
        assert (got == exp)
        else
        begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors != err_before)
            failed_tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "fail");
    endtask

    // expected scalar and ack latency from the reduction rules
    task automatic expected_result(input vred_pkg::vred_cmd_t c, output logic [31:0] exp,
                                   output int lat);
        int unsigned     w;
        int unsigned     n;
        longint          mask;
        longint          e;
        longint          acc;
        logic [SRC_W-1:0] sh;
        exp = '0;
        lat = 2;
        if ((int'(c.op) == 1 || int'(c.op) == 2) && int'(c.sew) < 3 && int'(c.lmul) < 3)
        begin
            w = 8 << int'(c.sew);
            n = (`VRED_VLEN << int'(c.lmul)) / w;
            mask = (longint'(1) << w) - 1;
            acc = (c.op == vred_pkg::VRED_MAX) ? -(longint'(1) << (w - 1)) : 0;
            // index n stands for the vs1 element combined last
            for (int i = 0; i <= n; i++)
            begin
                if (i < n)
                begin
                    sh = c.vs2 >> (i * w);
                    e = longint'(sh[31:0]) & mask;
                end
                else
                    e = longint'(c.vs1) & mask;
                if (c.op == vred_pkg::VRED_MAX)
                begin
                    if (e[w-1])
                        e = e - (longint'(1) << w);
                    if (e > acc)
                        acc = e;
                end
                else
                    acc = acc + e;
            end
            exp = 32'(acc & mask);
            lat = $clog2(n) + 2;
        end
    endtask

    // element i gets base + i * step across all 512 bits
    function automatic logic [SRC_W-1:0] fill_vec(input int w, input longint base,
                                                  input longint step);
        logic [SRC_W-1:0] v;
        logic [SRC_W-1:0] el;
        longint           mask;
        v = '0;
        mask = (longint'(1) << w) - 1;
        for (int i = 0; i < SRC_W / w; i++)
        begin
            el = '0;
            el[63:0] = (base + longint'(i) * step) & mask;
            v = v | (el << (i * w));
        end
        return v;
    endfunction

    function automatic logic [SRC_W-1:0] rand_vec();
        logic [SRC_W-1:0] v;
        for (int i = 0; i < SRC_W / 32; i++)
            v[i*32 +: 32] = $urandom();
        return v;
    endfunction

    function automatic vred_pkg::vred_cmd_t make_cmd(input int op, input int sew, input int lmul,
                                                     input logic [SRC_W-1:0] vs2,
                                                     input logic [31:0] vs1);
        vred_pkg::vred_cmd_t c;
        c.op = vred_pkg::vred_op_e'(3'(op));
        c.sew = vred_pkg::vred_sew_e'(2'(sew));
        c.lmul = vred_pkg::vred_lmul_e'(2'(lmul));
        c.vs2 = vs2;
        c.vs1 = vs1;
        return c;
    endfunction

    // one full four-phase transaction with req held for extra cycles after ack
    task automatic run_reduction(input string name, input vred_pkg::vred_cmd_t c,
                                 input int hold);
        logic [31:0] exp;
        int          exp_lat;
        int          lat;
        int          err_before;
        logic        ack_seen;
        err_before = errors;
        expected_result(c, exp, exp_lat);
        @(posedge clk);
        req <= 1'b1;
        cmd <= c;
        // req sampled here
        @(posedge clk);
        lat = 0;
        ack_seen = 1'b0;
        while (lat < MAX_WAIT && !ack_seen)
        begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            ack_seen = ack;
        end
        if (!ack_seen)
        begin
            $display("timeout: ack did not rise within %0d cycles", MAX_WAIT);
            errors++;
        end
        else
        begin
            check_value("ack_latency", lat, exp_lat);
            check_value("result", result, exp);
            for (int k = 0; k < hold; k++)
            begin
                @(negedge clk);
                check_value("ack", ack, 1);
                check_value("result", result, exp);
            end
        end
        @(posedge clk);
        req <= 1'b0;
        lat = 0;
        ack_seen = 1'b1;
        while (lat < MAX_WAIT && ack_seen)
        begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            ack_seen = ack;
        end
        if (ack_seen)
        begin
            $display("timeout: ack did not fall within %0d cycles after req fell", MAX_WAIT);
            errors++;
        end
        else
        begin
            check_value("ack_fall_latency", lat, 1);
            check_value("result", result, exp);
        end
        report_test(name, err_before);
    endtask

    // a nonzero result goes ahead so that a missing clear shows up
    task automatic run_illegal(input string name, input vred_pkg::vred_cmd_t c);
        run_reduction({"setup for ", name}, make_cmd(1, 2, 0, '0, 32'h5a), 0);
        run_reduction(name, c, 0);
    endtask

    initial
    begin
        int               n;
        int               w;
        int               op_v;
        int               s;
        int               l;
        int               err_before;
        longint           neg;
        logic [SRC_W-1:0] v;
        logic [SRC_W-1:0] keep;
        logic [SRC_W-1:0] big;
        logic [SRC_W-1:0] low;
        req = 1'b0;
        cmd = '0;
        tests = 0;
        failed_tests = 0;
        errors = 0;
        void'($urandom(32'h04eff3c8));

        err_before = errors;
        n = 0;
        while (nrst !== 1'b1 && n < MAX_WAIT)
        begin
            @(negedge clk);
            n++;
        end
        if (nrst !== 1'b1)
        begin
            $display("timeout: reset was never released");
            errors++;
        end
        check_value("ack", ack, 0);
        check_value("result", result, 0);
        report_test("reset state", err_before);

        // wrapping sums
        for (s = 0; s < 3; s++)
        begin
            w = 8 << s;
            v = fill_vec(w, -1, -3);
            run_reduction($sformatf("sum wrap sew%0d", w), make_cmd(1, s, 0, v, 32'hffff_fff0), 0);
        end

        // signed max with vs1 losing then winning
        for (s = 0; s < 3; s++)
        begin
            w = 8 << s;
            neg = -(longint'(1) << (w - 1));
            v = fill_vec(w, neg + 4, 3);
            run_reduction($sformatf("max negative sew%0d vs1 loses", w),
                          make_cmd(2, s, 0, v, 32'(neg)), 0);
            run_reduction($sformatf("max negative sew%0d vs1 wins", w),
                          make_cmd(2, s, 0, v, 32'hffff_fffe), 0);
            v = fill_vec(w, -7, 5);
            run_reduction($sformatf("max mixed sew%0d vs1 loses", w),
                          make_cmd(2, s, 0, v, 32'hffff_ffff), 0);
            run_reduction($sformatf("max mixed sew%0d vs1 wins", w),
                          make_cmd(2, s, 0, v, 32'd100), 0);
        end

        // most positive values parked beyond the active group
        for (s = 0; s < 3; s++)
        begin
            w = 8 << s;
            for (l = 0; l < 2; l++)
            begin
                for (op_v = 1; op_v <= 2; op_v++)
                begin
                    keep = fill_vec(w, -3, 2);
                    big = fill_vec(w, (longint'(1) << (w - 1)) - 1, 0);
                    low = '1;
                    low = low >> (SRC_W - (`VRED_VLEN << l));
                    v = (keep & low) | (big & ~low);
                    run_reduction($sformatf("mask op%0d sew%0d lmul%0d", op_v, w, 1 << l),
                                  make_cmd(op_v, s, l, v, 32'h3), 0);
                end
            end
            for (op_v = 1; op_v <= 2; op_v++)
                run_reduction($sformatf("full group op%0d sew%0d lmul4", op_v, w),
                              make_cmd(op_v, s, 2, rand_vec(), $urandom()), 0);
        end

        run_illegal("reserved sew", make_cmd(1, 3, 0, rand_vec(), 32'h5));
        run_illegal("reserved lmul", make_cmd(2, 0, 3, rand_vec(), 32'h5));
        run_illegal("unknown opcode 0", make_cmd(0, 0, 0, rand_vec(), 32'h5));
        run_illegal("unknown opcode 5", make_cmd(5, 1, 1, rand_vec(), 32'h5));

        run_reduction("held req sew16 lmul2", make_cmd(2, 1, 1, rand_vec(), $urandom()), 6);

        for (int t = 0; t < 40; t++)
        begin
            op_v = ($urandom_range(0, 7) == 0) ? $urandom_range(0, 7) : $urandom_range(1, 2);
            s = ($urandom_range(0, 7) == 0) ? 3 : $urandom_range(0, 2);
            l = ($urandom_range(0, 7) == 0) ? 3 : $urandom_range(0, 2);
            v = rand_vec();
            n = $urandom_range(0, 2);
            run_reduction($sformatf("random %0d op%0d sew%0d lmul%0d", t, op_v, s, l),
                          make_cmd(op_v, s, l, v, $urandom()), n);
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* verification/vred_clk_gen.sv */
module vred_clk_gen (
    output logic clk,
    output logic nrst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over four rising edges
    initial
    begin
        nrst = 1'b0;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
    end

endmodule

/* logic/vred_top.sv */
`include "vred_settings.svh"

module vred_top (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         req,
    input  vred_pkg::vred_cmd_t          cmd,
    output logic                         ack,
    output logic [`VRED_SCALAR_W-1:0]    result
);

    vred_pkg::vred_dp_action_e action;

    vred_ctrl i_ctrl (
        .clk    (clk),
        .nrst   (nrst),
        .req    (req),
        .cmd    (cmd),
        .ack    (ack),
        .action (action)
    );

    vred_datapath i_datapath (
        .clk    (clk),
        .nrst   (nrst),
        .action (action),
        .cmd    (cmd),
        .result (result)
    );

endmodule

/* logic/vred_ctrl.sv */
`include "vred_settings.svh"

module vred_ctrl (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         req,
    input  vred_pkg::vred_cmd_t          cmd,
    output logic                         ack,
    output vred_pkg::vred_dp_action_e    action
);

    localparam int LVL_W = $clog2(`VRED_MAX_LEVELS + 1);
    localparam int VLEN_LOG2 = $clog2(`VRED_VLEN);

    vred_pkg::vred_state_e state;
    vred_pkg::vred_state_e state_nxt;
    logic [LVL_W-1:0]      lvl_cnt;
    logic [LVL_W-1:0]      levels;
    logic                  legal;

    always_comb
    begin
        legal = (cmd.op inside {vred_pkg::VRED_SUM, vred_pkg::VRED_MAX}) &&
                (cmd.sew inside {vred_pkg::SEW_8, vred_pkg::SEW_16, vred_pkg::SEW_32}) &&
                (cmd.lmul inside {vred_pkg::LMUL_1, vred_pkg::LMUL_2, vred_pkg::LMUL_4});
        // log2 of 128 * LMUL / SEW
        levels = LVL_W'(VLEN_LOG2 - 3 + int'(cmd.lmul) - int'(cmd.sew));
    end

    always_comb
    begin
        state_nxt = state;
        action = vred_pkg::DP_IDLE;
        case (state)
            vred_pkg::IDLE:
            begin
                if (req)
                    state_nxt = vred_pkg::LOAD;
            end
            vred_pkg::LOAD:
            begin
                // illegal commands skip the tree and clear the result
                action = legal ? vred_pkg::DP_LOAD : vred_pkg::DP_CLEAR;
                state_nxt = legal ? vred_pkg::REDUCE : vred_pkg::MERGE;
            end
            vred_pkg::REDUCE:
            begin
                action = vred_pkg::DP_REDUCE;
                if (lvl_cnt == LVL_W'(1))
                    state_nxt = vred_pkg::MERGE;
            end
            vred_pkg::MERGE:
            begin
                action = legal ? vred_pkg::DP_MERGE : vred_pkg::DP_CLEAR;
                state_nxt = vred_pkg::HOLD_ACK;
            end
            vred_pkg::HOLD_ACK:
            begin
                // hold until the requester drops req
                if (!req)
                    state_nxt = vred_pkg::IDLE;
            end
            default:
            begin
                state_nxt = vred_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state <= vred_pkg::IDLE;
            lvl_cnt <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (state == vred_pkg::LOAD)
                lvl_cnt <= levels;
            else if (state == vred_pkg::REDUCE)
                lvl_cnt <= lvl_cnt - LVL_W'(1);
        end
    end

    assign ack = (state == vred_pkg::HOLD_ACK);

endmodule

/* logic/vred_datapath.sv */
`include "vred_settings.svh"

module vred_datapath (
    input  logic                         clk,
    input  logic                         nrst,
    input  vred_pkg::vred_dp_action_e    action,
    input  vred_pkg::vred_cmd_t          cmd,
    output logic [`VRED_SCALAR_W-1:0]    result
);

    localparam int SRC_W = `VRED_SRC_W;
    localparam int SCALAR_W = `VRED_SCALAR_W;

    logic [SRC_W-1:0] masked;
    logic [SRC_W-1:0] work_q;
    logic [SRC_W-1:0] merge_vec;
    logic [SRC_W-1:0] stage_in;
    logic [SRC_W-1:0] stage_out;

    vred_operand_mask i_mask (
        .vs2    (cmd.vs2),
        .sew    (cmd.sew),
        .lmul   (cmd.lmul),
        .op     (cmd.op),
        .masked (masked)
    );

    // merge reuses the tree stage: vs1 sits in element 1 next to the
    // reduced element 0, and pair 0 of the output is the final scalar
    always_comb
    begin
        merge_vec = work_q;
        case (cmd.sew)
            vred_pkg::SEW_8:  merge_vec[15:8] = cmd.vs1[7:0];
            vred_pkg::SEW_16: merge_vec[31:16] = cmd.vs1[15:0];
            default:          merge_vec[63:32] = cmd.vs1;
        endcase
        stage_in = (action == vred_pkg::DP_MERGE) ? merge_vec : work_q;
    end

    vred_tree_stage i_stage (
        .vec  (stage_in),
        .sew  (cmd.sew),
        .op   (cmd.op),
        .half (stage_out)
    );

    always_ff @(posedge clk)
    begin
        case (action)
            vred_pkg::DP_LOAD:   work_q <= masked;
            vred_pkg::DP_REDUCE: work_q <= stage_out;
            default:             work_q <= work_q;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            result <= '0;
        end
        else if (action == vred_pkg::DP_MERGE)
        begin
            // zero-extend to the scalar width
            case (cmd.sew)
                vred_pkg::SEW_8:  result <= {{(SCALAR_W-8){1'b0}}, stage_out[7:0]};
                vred_pkg::SEW_16: result <= {{(SCALAR_W-16){1'b0}}, stage_out[15:0]};
                default:          result <= stage_out[SCALAR_W-1:0];
            endcase
        end
        else if (action == vred_pkg::DP_CLEAR)
        begin
            result <= '0;
        end
    end

endmodule

/* logic/vred_tree_stage.sv */
`include "vred_settings.svh"

module vred_tree_stage (
    input  logic [`VRED_SRC_W-1:0] vec,
    input  vred_pkg::vred_sew_e    sew,
    input  vred_pkg::vred_op_e     op,
    output logic [`VRED_SRC_W-1:0] half
);

    localparam int SRC_W = `VRED_SRC_W;
    localparam int HALF_W = SRC_W / 2;
    localparam int SCALAR_W = `VRED_SCALAR_W;

    // operands are moved to the top of the word so that the signed
    // compare and the wrapping add behave as w-bit operations
    function automatic logic [SCALAR_W-1:0] pair_op(input logic [SCALAR_W-1:0] a,
                                                    input logic [SCALAR_W-1:0] b,
                                                    input int unsigned w,
                                                    input vred_pkg::vred_op_e op_sel);
        logic [SCALAR_W-1:0] a_top;
        logic [SCALAR_W-1:0] b_top;
        logic [SCALAR_W-1:0] r;
        a_top = a << (SCALAR_W - w);
        b_top = b << (SCALAR_W - w);
        if (op_sel == vred_pkg::VRED_MAX)
            r = ($signed(a_top) >= $signed(b_top)) ? a_top : b_top;
        else
            r = a_top + b_top;
        return r >> (SCALAR_W - w);
    endfunction

    always_comb
    begin
        logic [SCALAR_W-1:0] r;
        r = '0;
        // upper half is refilled with the identity
        half = vred_pkg::vred_identity(op, sew);
        case (sew)
            vred_pkg::SEW_8:
            begin
                for (int j = 0; j < HALF_W / 8; j++)
                begin
                    r = pair_op(vec[16*j +: 8], vec[16*j+8 +: 8], 8, op);
                    half[8*j +: 8] = r[7:0];
                end
            end
            vred_pkg::SEW_16:
            begin
                for (int j = 0; j < HALF_W / 16; j++)
                begin
                    r = pair_op(vec[32*j +: 16], vec[32*j+16 +: 16], 16, op);
                    half[16*j +: 16] = r[15:0];
                end
            end
            vred_pkg::SEW_32:
            begin
                for (int j = 0; j < HALF_W / 32; j++)
                begin
                    r = pair_op(vec[64*j +: 32], vec[64*j+32 +: 32], 32, op);
                    half[32*j +: 32] = r;
                end
            end
            default:
            begin
                // reserved width, identity only
                r = '0;
            end
        endcase
    end

endmodule

/* logic/vred_operand_mask.sv */
`include "vred_settings.svh"

module vred_operand_mask (
    input  logic [`VRED_SRC_W-1:0] vs2,
    input  vred_pkg::vred_sew_e    sew,
    input  vred_pkg::vred_lmul_e   lmul,
    input  vred_pkg::vred_op_e     op,
    output logic [`VRED_SRC_W-1:0] masked
);

    localparam int SRC_BYTES = `VRED_SRC_W / 8;
    localparam int REG_BYTES = `VRED_VLEN / 8;

    logic [`VRED_SRC_W-1:0] ident;
    int unsigned            active_bytes;

    // group ends on a register boundary, so elements are never split
    always_comb
    begin
        active_bytes = REG_BYTES << int'(lmul);
        ident = vred_pkg::vred_identity(op, sew);
        for (int b = 0; b < SRC_BYTES; b++)
        begin
            if (b < active_bytes)
                masked[b*8 +: 8] = vs2[b*8 +: 8];
            else
                masked[b*8 +: 8] = ident[b*8 +: 8];
        end
    end

endmodule

/* logic/vred_pkg.sv */
`include "vred_settings.svh"

package vred_pkg;

    // codes other than these two are unknown
    typedef enum logic [`VRED_OP_W-1:0]
    {
        VRED_SUM = 1,
        VRED_MAX = 2
    } vred_op_e;

    // code 3 reserved
    typedef enum logic [1:0]
    {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } vred_sew_e;

    // code 3 reserved
    typedef enum logic [1:0]
    {
        LMUL_1 = 2'd0,
        LMUL_2 = 2'd1,
        LMUL_4 = 2'd2
    } vred_lmul_e;

    typedef enum logic [2:0]
    {
        IDLE,
        LOAD,
        REDUCE,
        MERGE,
        HOLD_ACK
    } vred_state_e;

    typedef enum logic [2:0]
    {
        DP_IDLE,
        DP_LOAD,
        DP_REDUCE,
        DP_MERGE,
        DP_CLEAR
    } vred_dp_action_e;

    typedef struct packed
    {
        vred_op_e                  op;
        vred_sew_e                 sew;
        vred_lmul_e                lmul;
        logic [`VRED_SRC_W-1:0]    vs2;
        logic [`VRED_SCALAR_W-1:0] vs1;
    } vred_cmd_t;

    // every element set to the neutral value of the operation
    // zero for sum, most negative number for max
    function automatic logic [`VRED_SRC_W-1:0] vred_identity(input vred_op_e op,
                                                             input vred_sew_e sew);
        logic [`VRED_SRC_W-1:0] v;
        int unsigned            top_sel;
        v = '0;
        top_sel = (1 << int'(sew)) - 1;
        if (op == VRED_MAX)
        begin
            for (int b = 0; b < `VRED_SRC_W / 8; b++)
            begin
                // sign byte of each element
                if ((b & top_sel) == top_sel)
                    v[b*8 +: 8] = 8'h80;
            end
        end
        return v;
    endfunction

endpackage

/* logic/vred_settings.svh */
`ifndef VRED_SETTINGS_SVH
`define VRED_SETTINGS_SVH

// bits per vector register
`define VRED_VLEN 128

// whole source group, four registers at LMUL 4
`define VRED_SRC_W 512

`define VRED_SCALAR_W 32

`define VRED_OP_W 3

// 64 elements of 8 bits
`define VRED_MAX_LEVELS 6

`endif
